// File: rtl/net_req_defines.svh
/*
 * net request subsystem sizes.
 * session count and field widths shared by the package and the table.
 */
`ifndef NET_REQ_DEFINES_SVH
`define NET_REQ_DEFINES_SVH

`define NREQ_SESSIONS 16  // 4-bit session id.
`define NREQ_SEQ_BITS 32  // tcp sequence number.
`define NREQ_LEN_BITS 16  // request length in bytes.

`endif

// File: rtl/net_req_pkg.sv
/*
 * net request types.
 * request, table access and transmit descriptor bundles, engine states.
 */
`include "net_req_defines.svh"

package net_req_pkg;

  typedef logic [$clog2(`NREQ_SESSIONS)-1:0] sid_t;
  typedef logic [`NREQ_SEQ_BITS-1:0] seq_t;
  typedef logic [`NREQ_LEN_BITS-1:0] len_t;

  // host request, seq only meaningful for commands.
  typedef struct packed {
    logic mode;   // 1 cmd, 0 write.
    sid_t sid;
    len_t len;
    seq_t seq;    // new base for a command.
  } req_t;

  // one access to the sequence table.
  typedef struct packed {
    logic wr;
    sid_t sid;
    seq_t wdata;
  } tbl_req_t;

  typedef struct packed {
    sid_t sid;
    seq_t seq;
    len_t len;
  } tx_desc_t;

  typedef enum logic [1:0] {CMD_IDLE, CMD_WRITE, CMD_ACK} cmd_state_e;

  typedef enum logic [2:0] {WR_IDLE, WR_READ, WR_WAIT, WR_WRITE, WR_EMIT} wr_state_e;

endpackage

// File: rtl/meta_reg.sv
/*
 * one-entry valid/ready register slice.
 * carries any packed payload, full throughput when drained every cycle.
 */
`timescale 1ns/100ps

module meta_reg #(
  parameter int DATA_BITS = 32
) (
  input  logic                 aclk,
  input  logic                 rst_n,

  input  logic                 s_valid,
  input  logic [DATA_BITS-1:0] s_data,
  output logic                 s_ready,

  output logic                 m_valid,
  output logic [DATA_BITS-1:0] m_data,
  input  logic                 m_ready
);

  logic                 valid_q;  // slice occupied.
  logic [DATA_BITS-1:0] data_q;

  // take a new beat when empty or when the held one leaves.
  assign s_ready = !valid_q || m_ready;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) valid_q <= 1'b0;
    else if (s_ready) valid_q <= s_valid;  // refill or drain.
  end

  always_ff @(posedge aclk) begin
    if (s_valid && s_ready) data_q <= s_data;
  end

  assign m_valid = valid_q;
  assign m_data  = data_q;

endmodule

// File: rtl/dreq_mux_net.sv
/*
 * host request splitter.
 * mode 1 goes to the tcp command path, mode 0 to the tcp write path.
 */
`timescale 1ns/100ps

module dreq_mux_net (
  input  logic                aclk,
  input  logic                rst_n,

  input  logic                req_valid,   // host.
  input  net_req_pkg::req_t   req_data,
  output logic                req_ready,

  output logic                cmd_valid,   // tcp cmd.
  output net_req_pkg::req_t   cmd_data,
  input  logic                cmd_ready,

  output logic                wr_valid,    // tcp wr.
  output net_req_pkg::req_t   wr_data,
  input  logic                wr_ready
);

  logic cmd_in_valid, cmd_in_ready;
  logic wr_in_valid, wr_in_ready;

  // steer by mode, ready only from the chosen slice.
  always_comb begin
    req_ready    = 1'b0;
    cmd_in_valid = 1'b0;
    wr_in_valid  = 1'b0;
    if (req_valid) begin
      if (req_data.mode) begin
        cmd_in_valid = 1'b1;
        req_ready    = cmd_in_ready;
      end else begin
        wr_in_valid = 1'b1;
        req_ready   = wr_in_ready;
      end
    end
  end

  meta_reg #(.DATA_BITS($bits(net_req_pkg::req_t))) u_reg_cmd (.aclk(aclk), .rst_n(rst_n),
    .s_valid(cmd_in_valid), .s_data(req_data), .s_ready(cmd_in_ready),
    .m_valid(cmd_valid), .m_data(cmd_data), .m_ready(cmd_ready));

  meta_reg #(.DATA_BITS($bits(net_req_pkg::req_t))) u_reg_wr (.aclk(aclk), .rst_n(rst_n),
    .s_valid(wr_in_valid), .s_data(req_data), .s_ready(wr_in_ready),
    .m_valid(wr_valid), .m_data(wr_data), .m_ready(wr_ready));

endmodule

// File: rtl/tcp_cmd_engine.sv
/*
 * tcp command engine.
 * sets a session's sequence base in the table, then strobes an ack.
 */
`timescale 1ns/100ps

module tcp_cmd_engine (
  input  logic                    aclk,
  input  logic                    rst_n,

  input  logic                    cmd_valid,
  input  net_req_pkg::req_t       cmd_data,
  output logic                    cmd_ready,

  output logic                    tbl_valid,
  output net_req_pkg::tbl_req_t   tbl_req,
  input  logic                    tbl_gnt,

  output logic                    cmd_ack,
  output net_req_pkg::sid_t       cmd_ack_sid
);

  net_req_pkg::cmd_state_e state_q, state_d;
  net_req_pkg::sid_t       sid_q;   // held request.
  net_req_pkg::seq_t       base_q;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) state_q <= net_req_pkg::CMD_IDLE;
    else state_q <= state_d;
  end

  // payload, loaded on accept only.
  always_ff @(posedge aclk) begin
    if (cmd_valid && cmd_ready) begin
      sid_q  <= cmd_data.sid;
      base_q <= cmd_data.seq;
    end
  end

  always_comb begin
    state_d   = state_q;
    cmd_ready = 1'b0;
    tbl_valid = 1'b0;
    cmd_ack   = 1'b0;
    case (state_q)
      net_req_pkg::CMD_IDLE: begin
        cmd_ready = 1'b1;
        if (cmd_valid) state_d = net_req_pkg::CMD_WRITE;
      end
      net_req_pkg::CMD_WRITE: begin
        tbl_valid = 1'b1;                                  // hold until granted.
        if (tbl_gnt) state_d = net_req_pkg::CMD_ACK;      // write lands this cycle.
      end
      net_req_pkg::CMD_ACK: begin
        cmd_ack = 1'b1;
        state_d = net_req_pkg::CMD_IDLE;
      end
      default: state_d = net_req_pkg::CMD_IDLE;
    endcase
  end

  assign tbl_req     = '{wr: 1'b1, sid: sid_q, wdata: base_q};
  assign cmd_ack_sid = sid_q;

endmodule

// File: rtl/tcp_wr_engine.sv
/*
 * tcp write engine.
 * reads the session's sequence number, writes back seq + len,
 * then offers a transmit descriptor carrying the old number.
 */
`timescale 1ns/100ps
`include "net_req_defines.svh"

module tcp_wr_engine (
  input  logic                    aclk,
  input  logic                    rst_n,

  input  logic                    wr_valid,
  input  net_req_pkg::req_t       wr_data,
  output logic                    wr_ready,

  output logic                    tbl_valid,
  output net_req_pkg::tbl_req_t   tbl_req,
  input  logic                    tbl_gnt,
  input  net_req_pkg::seq_t       mem_rdata,   // shared read bus.

  output logic                    tx_valid,
  output net_req_pkg::tx_desc_t   tx_desc,
  input  logic                    tx_ready
);

  net_req_pkg::wr_state_e state_q, state_d;
  net_req_pkg::sid_t      sid_q;
  net_req_pkg::len_t      len_q;
  net_req_pkg::seq_t      seq_q;     // number read from the table.
  net_req_pkg::seq_t      seq_next;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) state_q <= net_req_pkg::WR_IDLE;
    else state_q <= state_d;
  end

  always_ff @(posedge aclk) begin
    if (wr_valid && wr_ready) begin
      sid_q <= wr_data.sid;
      len_q <= wr_data.len;
    end
    if (state_q == net_req_pkg::WR_WAIT) seq_q <= mem_rdata;  // our read is back.
  end

  // wraps at the sequence width.
  assign seq_next = seq_q + {{(`NREQ_SEQ_BITS - `NREQ_LEN_BITS){1'b0}}, len_q};

  always_comb begin
    state_d   = state_q;
    wr_ready  = 1'b0;
    tbl_valid = 1'b0;
    tbl_req   = '{wr: 1'b0, sid: sid_q, wdata: seq_next};
    tx_valid  = 1'b0;
    case (state_q)
      net_req_pkg::WR_IDLE: begin
        wr_ready = 1'b1;
        if (wr_valid) state_d = net_req_pkg::WR_READ;
      end
      net_req_pkg::WR_READ: begin
        tbl_valid = 1'b1;   // read request.
        if (tbl_gnt) state_d = net_req_pkg::WR_WAIT;
      end
      net_req_pkg::WR_WAIT: begin
        state_d = net_req_pkg::WR_WRITE;  // rdata valid now.
      end
      net_req_pkg::WR_WRITE: begin
        tbl_valid  = 1'b1;
        tbl_req.wr = 1'b1;  // write back seq + len.
        if (tbl_gnt) state_d = net_req_pkg::WR_EMIT;
      end
      net_req_pkg::WR_EMIT: begin
        tx_valid = 1'b1;    // stalls here under back-pressure.
        if (tx_ready) state_d = net_req_pkg::WR_IDLE;
      end
      default: state_d = net_req_pkg::WR_IDLE;
    endcase
  end

  assign tx_desc = '{sid: sid_q, seq: seq_q, len: len_q};

endmodule

// File: rtl/seq_table_arbiter.sv
/*
 * round-robin arbiter for the single sequence table port.
 * port 0 is the command engine, port 1 the write engine.
 */
`timescale 1ns/100ps

module seq_table_arbiter (
  input  logic                    aclk,
  input  logic                    rst_n,

  input  logic                    tbl_valid_0,
  input  net_req_pkg::tbl_req_t   tbl_req_0,
  output logic                    tbl_gnt_0,

  input  logic                    tbl_valid_1,
  input  net_req_pkg::tbl_req_t   tbl_req_1,
  output logic                    tbl_gnt_1,

  output logic                    mem_en,
  output net_req_pkg::tbl_req_t   mem_req
);

  logic last_q;  // 1 when port 1 won the last grant.
  logic busy_q;  // grant given last cycle.

  // no back-to-back grants, so a winner can drop its request first.
  always_comb begin
    tbl_gnt_0 = 1'b0;
    tbl_gnt_1 = 1'b0;
    if (!busy_q) begin
      if (tbl_valid_0 && tbl_valid_1) begin
        tbl_gnt_0 = last_q;   // conflict, alternate.
        tbl_gnt_1 = !last_q;
      end else begin
        tbl_gnt_0 = tbl_valid_0;
        tbl_gnt_1 = tbl_valid_1;
      end
    end
  end

  assign mem_en  = tbl_gnt_0 || tbl_gnt_1;
  assign mem_req = tbl_gnt_1 ? tbl_req_1 : tbl_req_0;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      last_q <= 1'b1;  // command engine first after reset.
      busy_q <= 1'b0;
    end else begin
      busy_q <= mem_en;
      if (mem_en) last_q <= tbl_gnt_1;
    end
  end

endmodule

// File: rtl/seq_table.sv
/*
 * per-session sequence number table.
 * one port, reset to zero, registered read one cycle after the strobe.
 */
`timescale 1ns/100ps
`include "net_req_defines.svh"

module seq_table (
  input  logic                    aclk,
  input  logic                    rst_n,

  input  logic                    mem_en,
  input  net_req_pkg::tbl_req_t   mem_req,
  output net_req_pkg::seq_t       mem_rdata
);

  net_req_pkg::seq_t mem [`NREQ_SESSIONS];

  // cleared so a fresh session starts at zero.
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NREQ_SESSIONS; i++) begin
        mem[i] <= '0;
      end
    end else if (mem_en && mem_req.wr) begin
      mem[mem_req.sid] <= mem_req.wdata;
    end
  end

  // read port, holds its value until the next read.
  always_ff @(posedge aclk) begin
    if (mem_en && !mem_req.wr) mem_rdata <= mem[mem_req.sid];
  end

endmodule

// File: rtl/net_req_top.sv
/*
 * net request subsystem top.
 * splitter, tcp command and write engines, table arbiter and table.
 */
`timescale 1ns/100ps

module net_req_top (
  input  logic                    aclk,
  input  logic                    rst_n,

  input  logic                    req_valid,
  input  net_req_pkg::req_t       req_data,
  output logic                    req_ready,

  output logic                    cmd_ack,
  output net_req_pkg::sid_t       cmd_ack_sid,

  output logic                    tx_valid,
  output net_req_pkg::tx_desc_t   tx_desc,
  input  logic                    tx_ready
);

  net_req_pkg::req_t     cmd_data, wr_data;
  logic                  cmd_valid, cmd_ready;
  logic                  wr_valid, wr_ready;

  net_req_pkg::tbl_req_t tbl_req_0, tbl_req_1;  // 0 cmd, 1 wr.
  logic                  tbl_valid_0, tbl_gnt_0;
  logic                  tbl_valid_1, tbl_gnt_1;

  net_req_pkg::tbl_req_t mem_req;
  logic                  mem_en;
  net_req_pkg::seq_t     mem_rdata;

  dreq_mux_net u_mux (
    .aclk(aclk), .rst_n(rst_n),
    .req_valid(req_valid), .req_data(req_data), .req_ready(req_ready),
    .cmd_valid(cmd_valid), .cmd_data(cmd_data), .cmd_ready(cmd_ready),
    .wr_valid(wr_valid), .wr_data(wr_data), .wr_ready(wr_ready)
  );

  tcp_cmd_engine u_cmd (
    .aclk(aclk), .rst_n(rst_n),
    .cmd_valid(cmd_valid), .cmd_data(cmd_data), .cmd_ready(cmd_ready),
    .tbl_valid(tbl_valid_0), .tbl_req(tbl_req_0), .tbl_gnt(tbl_gnt_0),
    .cmd_ack(cmd_ack), .cmd_ack_sid(cmd_ack_sid)
  );

  tcp_wr_engine u_wr (
    .aclk(aclk), .rst_n(rst_n),
    .wr_valid(wr_valid), .wr_data(wr_data), .wr_ready(wr_ready),
    .tbl_valid(tbl_valid_1), .tbl_req(tbl_req_1), .tbl_gnt(tbl_gnt_1),
    .mem_rdata(mem_rdata),
    .tx_valid(tx_valid), .tx_desc(tx_desc), .tx_ready(tx_ready)
  );

  seq_table_arbiter u_arb (
    .aclk(aclk), .rst_n(rst_n),
    .tbl_valid_0(tbl_valid_0), .tbl_req_0(tbl_req_0), .tbl_gnt_0(tbl_gnt_0),
    .tbl_valid_1(tbl_valid_1), .tbl_req_1(tbl_req_1), .tbl_gnt_1(tbl_gnt_1),
    .mem_en(mem_en), .mem_req(mem_req)
  );

  // read data goes straight to both engines.
  seq_table u_tbl (
    .aclk(aclk), .rst_n(rst_n),
    .mem_en(mem_en), .mem_req(mem_req), .mem_rdata(mem_rdata)
  );

endmodule

// File: testbench/net_req_checker.sv
/*
 * net request checker.
 * watches the top level ports, keeps a model of the sequence table
 * and compares every acknowledge and descriptor against it.
 */
`timescale 1ns/100ps
`include "net_req_defines.svh"

module net_req_checker (
  input  logic                  aclk,
  input  logic                  rst_n,
  input  logic                  req_valid,
  input  net_req_pkg::req_t     req_data,
  input  logic                  req_ready,
  input  net_req_pkg::seq_t     exp_seq,     // table value for the write being offered.
  input  logic                  cmd_ack,
  input  net_req_pkg::sid_t     cmd_ack_sid,
  input  logic                  tx_valid,
  input  net_req_pkg::tx_desc_t tx_desc,
  input  logic                  tx_ready,
  output int                    err_count,
  output int                    cmd_pending,
  output int                    wr_pending
);

  net_req_pkg::req_t cmd_q[$];   // commands awaiting ack.
  net_req_pkg::req_t wr_q[$];    // writes awaiting a descriptor.
  net_req_pkg::seq_t exp_q[$];
  net_req_pkg::seq_t model [`NREQ_SESSIONS];

  always @(posedge aclk or negedge rst_n) begin : check_ports
    net_req_pkg::req_t r;
    net_req_pkg::seq_t e;
    if (!rst_n) begin
      for (int i = 0; i < `NREQ_SESSIONS; i++) model[i] = '0;  // table clears on reset.
      cmd_q.delete();
      wr_q.delete();
      exp_q.delete();
      err_count = 0;
    end else begin
      if (cmd_ack) begin
        if (cmd_q.size() == 0) begin
          err_count++;
          $display("ERROR %0t: cmd_ack for sid %0d with no command outstanding",
                   $time, cmd_ack_sid);
        end else begin
          r = cmd_q.pop_front();
          if (cmd_ack_sid != r.sid) begin
            err_count++;
            $display("ERROR %0t: cmd_ack sid %0d, expected %0d", $time, cmd_ack_sid, r.sid);
          end
          model[r.sid] = r.seq;  // new base.
        end
      end
      if (tx_valid && tx_ready) begin
        if (wr_q.size() == 0) begin
          err_count++;
          $display("ERROR %0t: descriptor for sid %0d with no write outstanding",
                   $time, tx_desc.sid);
        end else begin
          r = wr_q.pop_front();
          e = exp_q.pop_front();
          if (tx_desc.sid != r.sid || tx_desc.len != r.len) begin
            err_count++;
            $display("ERROR %0t: descriptor sid %0d len %0d, expected sid %0d len %0d",
                     $time, tx_desc.sid, tx_desc.len, r.sid, r.len);
          end
          if (tx_desc.seq != model[r.sid] || tx_desc.seq != e) begin
            err_count++;
            $display("ERROR %0t: sid %0d seq %h, model %h, table %h",
                     $time, r.sid, tx_desc.seq, model[r.sid], e);
          end
          model[r.sid] = model[r.sid] + net_req_pkg::seq_t'(r.len);  // wraps at 32 bits.
        end
      end
      if (req_valid && req_ready) begin
        if (req_data.mode) begin
          cmd_q.push_back(req_data);
        end else begin
          wr_q.push_back(req_data);
          exp_q.push_back(exp_seq);
        end
      end
    end
    cmd_pending = cmd_q.size();
    wr_pending  = wr_q.size();
  end

endmodule

// File: testbench/tb_net_req.sv
/*
 * net request subsystem testbench.
 * table-driven host requests, random tx back-pressure, cycle timeout.
 */
`timescale 1ns/100ps

module tb_net_req;

  typedef struct packed {
    logic              mode;
    net_req_pkg::sid_t sid;
    net_req_pkg::len_t len;
    net_req_pkg::seq_t seq;
    logic              wait_ack;  // hold off until every command is acked.
    net_req_pkg::seq_t exp_seq;   // expected descriptor seq for a write.
  } stim_t;

  logic                  aclk;
  logic                  rst_n;
  logic                  req_valid;
  net_req_pkg::req_t     req_data;
  logic                  req_ready;
  logic                  cmd_ack;
  net_req_pkg::sid_t     cmd_ack_sid;
  logic                  tx_valid;
  net_req_pkg::tx_desc_t tx_desc;
  logic                  tx_ready;

  net_req_pkg::seq_t exp_seq;
  int          err_count;
  int          cmd_pending;
  int          wr_pending;
  stim_t       stim_q[$];
  int          throttle_from;  // first throttled entry.
  logic        throttle;
  logic        fired;          // host handshake at the last edge.
  logic [31:0] rnd;
  int          cycles;
  int          limit;

  always #5 aclk = ~aclk;

  net_req_top DUT (
    .aclk(aclk), .rst_n(rst_n),
    .req_valid(req_valid), .req_data(req_data), .req_ready(req_ready),
    .cmd_ack(cmd_ack), .cmd_ack_sid(cmd_ack_sid),
    .tx_valid(tx_valid), .tx_desc(tx_desc), .tx_ready(tx_ready)
  );

  net_req_checker u_chk (
    .aclk(aclk), .rst_n(rst_n),
    .req_valid(req_valid), .req_data(req_data), .req_ready(req_ready),
    .exp_seq(exp_seq), .cmd_ack(cmd_ack), .cmd_ack_sid(cmd_ack_sid),
    .tx_valid(tx_valid), .tx_desc(tx_desc), .tx_ready(tx_ready),
    .err_count(err_count), .cmd_pending(cmd_pending), .wr_pending(wr_pending)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic add_cmd(input net_req_pkg::sid_t sid, input net_req_pkg::seq_t base,
                         input logic wait_ack);
    stim_t s;
    s = '{mode: 1'b1, sid: sid, len: '0, seq: base, wait_ack: wait_ack, exp_seq: '0};
    stim_q.push_back(s);
  endtask

  // junk seq field that the write path ignores.
  task automatic add_wr(input net_req_pkg::sid_t sid, input net_req_pkg::len_t len,
                        input net_req_pkg::seq_t exp);
    stim_t s;
    s = '{mode: 1'b0, sid: sid, len: len, seq: 32'h5a5a_5a5a, wait_ack: 1'b0, exp_seq: exp};
    stim_q.push_back(s);
  endtask

  task automatic build_table();
    add_wr(4'd3, 16'd100, 32'h0000_0000);           // untouched session reads zero.
    add_cmd(4'd4, 32'h1000_0000, 1'b1);
    add_wr(4'd4, 16'd64, 32'h1000_0000);
    add_cmd(4'd5, 32'hffff_ff00, 1'b1);             // wrap run.
    add_wr(4'd5, 16'h0080, 32'hffff_ff00);
    add_wr(4'd5, 16'h0090, 32'hffff_ff80);
    add_wr(4'd5, 16'h0010, 32'h0000_0010);
    add_wr(4'd5, 16'h0020, 32'h0000_0020);
    add_cmd(4'd6, 32'h00a0_0000, 1'b0);             // mixed modes.
    add_wr(4'd3, 16'd20, 32'd100);
    add_cmd(4'd7, 32'h0000_0007, 1'b1);
    add_wr(4'd7, 16'd1, 32'h0000_0007);
    throttle_from = stim_q.size();                  // tx back-pressure from here.
    add_wr(4'd8, 16'h0010, 32'h0000_0000);
    add_cmd(4'd9, 32'h5555_0000, 1'b0);
    add_wr(4'd8, 16'h0010, 32'h0000_0010);
    add_wr(4'd8, 16'h0010, 32'h0000_0020);
    add_cmd(4'd9, 32'h5555_1000, 1'b1);
    add_wr(4'd8, 16'h0010, 32'h0000_0030);
    add_wr(4'd9, 16'd8, 32'h5555_1000);
    add_wr(4'd9, 16'd8, 32'h5555_1008);
    add_cmd(4'd10, 32'h0000_0100, 1'b0);            // table contention.
    add_wr(4'd11, 16'd5, 32'h0000_0000);
    add_cmd(4'd10, 32'h0000_0200, 1'b0);
    add_wr(4'd12, 16'd6, 32'h0000_0000);
    add_cmd(4'd10, 32'h0000_0300, 1'b1);
    add_wr(4'd11, 16'd7, 32'h0000_0005);
    add_wr(4'd10, 16'h0040, 32'h0000_0300);
    add_wr(4'd10, 16'd1, 32'h0000_0340);
    add_wr(4'd12, 16'd2, 32'h0000_0006);
  endtask

  always @(posedge aclk) fired <= req_valid && req_ready;

  // tx_ready toggles at random while throttled.
  always @(posedge aclk) begin : drive_tx_ready
    logic hold;
    hold = throttle;  // taken at the edge before the stimulus loop moves on.
    #1;
    rnd = xorshift(rnd);
    tx_ready = hold ? rnd[0] : 1'b1;
  end

  always @(posedge aclk) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("errors: %0d mismatches, %0d commands outstanding, %0d writes outstanding",
               err_count, cmd_pending, wr_pending);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin : run_stimulus
    stim_t s;
    int    n;
    int    total;
    aclk      = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_data  = '0;
    tx_ready  = 1'b0;
    exp_seq   = '0;
    throttle  = 1'b0;
    rnd       = 32'h3f17_764f;
    cycles    = 0;
    build_table();
    limit = stim_q.size() * 40;
    repeat (8) @(posedge aclk);
    #1 rst_n = 1'b1;
    for (int i = 0; i < stim_q.size(); i++) begin
      s         = stim_q[i];
      throttle  = (i >= throttle_from);
      req_valid = 1'b1;
      req_data  = '{mode: s.mode, sid: s.sid, len: s.len, seq: s.seq};
      exp_seq   = s.exp_seq;
      do begin
        @(posedge aclk);
        #1;
      end while (!fired);  // held until req_ready.
      req_valid = 1'b0;
      while (s.wait_ack && cmd_pending != 0) begin  // keeps writes behind the command.
        @(posedge aclk);
        #1;
      end
    end
    throttle = 1'b0;
    n = 0;
    while ((cmd_pending != 0 || wr_pending != 0) && n < 200) begin  // drain.
      @(posedge aclk);
      #1;
      n++;
    end
    repeat (5) @(posedge aclk);
    if (cmd_pending != 0) $display("%0d command(s) were never acknowledged", cmd_pending);
    if (wr_pending != 0) $display("%0d write(s) never produced a descriptor", wr_pending);
    total = err_count + cmd_pending + wr_pending;
    $display("errors: %0d mismatches, %0d commands outstanding, %0d writes outstanding",
             err_count, cmd_pending, wr_pending);
    if (total == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+rtl
rtl/net_req_pkg.sv
rtl/meta_reg.sv
rtl/dreq_mux_net.sv
rtl/tcp_cmd_engine.sv
rtl/tcp_wr_engine.sv
rtl/seq_table_arbiter.sv
rtl/seq_table.sv
rtl/net_req_top.sv
testbench/net_req_checker.sv
testbench/tb_net_req.sv

// File: run_sim.sh
#!/bin/sh
# build and run the net request testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_net_req -o sim_net_req \
  || { echo "build failed"; exit 1; }

out="$(./obj_dir/sim_net_req)"
echo "$out"

echo "$out" | grep -q "TESTBENCH PASSED" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
